// File: compile.f
+incdir+hdl
hdl/eth_rx_frame_pkg.sv
hdl/eth_rx_axil_pkg.sv
hdl/eth_rx_mii.sv
hdl/eth_rx_crc.sv
hdl/eth_rx_mac_filter.sv
hdl/eth_rx_frame_store.sv
hdl/eth_rx_axil_regs.sv
hdl/eth_rx_top.sv
testbench/eth_rx_asserts.sv
testbench/eth_rx_tb.sv

// File: hdl/eth_rx_axil_pkg.sv
package eth_rx_axil_pkg;

   localparam int AXIL_ADDR_W = 12;
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

   typedef enum logic [1:0] {
      AXIL_OKAY   = 2'b00,
      AXIL_SLVERR = 2'b10
   } axil_resp_t;

   typedef struct packed {
      logic                   valid;
      logic [AXIL_ADDR_W-1:0] addr;
   } axil_aw_t;

   typedef struct packed {
      logic                   valid;
      logic [AXIL_DATA_W-1:0] data;
      logic [AXIL_STRB_W-1:0] strb;
   } axil_w_t;

   typedef struct packed {
      logic       valid;
      axil_resp_t resp;
   } axil_b_t;

   typedef struct packed {
      logic                   valid;
      logic [AXIL_ADDR_W-1:0] addr;
   } axil_ar_t;

   typedef struct packed {
      logic                   valid;
      logic [AXIL_DATA_W-1:0] data;
      axil_resp_t             resp;
   } axil_r_t;

endpackage

// File: hdl/eth_rx_axil_regs.sv
`include "eth_rx_config.svh"

module eth_rx_axil_regs
   import eth_rx_frame_pkg::*;
   import eth_rx_axil_pkg::*;
(
   input  logic        RX_CLK,
   input  logic        rx_rst,
   input  axil_aw_t    s_aw,
   output logic        s_awready,
   input  axil_w_t     s_w,
   output logic        s_wready,
   output axil_b_t     s_b,
   input  logic        s_bready,
   input  axil_ar_t    s_ar,
   output logic        s_arready,
   output axil_r_t     s_r,
   input  logic        s_rready,
   input  logic        frame_ready,
   input  frame_len_t  frame_len,
   input  logic [15:0] drop_count,
   input  logic [31:0] rd_data,
   output logic [8:0]  rd_addr,
   output logic        buf_release
);

   logic        awready_q;
   logic        bvalid_q;
   logic        arready_q;
   logic        rvalid_q;
   logic [8:0]  rd_addr_q;
   logic        rsel_buf_q;
   logic [31:0] rdata_q;
   axil_resp_t  rresp_q;
   logic        wr_go;
   logic        rd_go;
   logic [11:0] ar_off;
   logic        ar_in_buf;

   assign s_awready = awready_q;
   assign s_wready  = awready_q;
   assign s_arready = arready_q;
   assign wr_go     = s_aw.valid && s_w.valid && awready_q;
   assign rd_go     = s_ar.valid && arready_q;

   assign ar_off    = s_ar.addr - `ETH_RX_REG_DATA;
   assign ar_in_buf = (s_ar.addr >= `ETH_RX_REG_DATA) && (ar_off < `ETH_RX_BUF_BYTES);
   // buffer sees the new word address in the accept cycle
   assign rd_addr   = rd_go ? ar_off[10:2] : rd_addr_q;

   assign buf_release = wr_go && (s_aw.addr == `ETH_RX_REG_STATUS) &&
                        s_w.strb[0] && s_w.data[0] && frame_ready;

   assign s_b = '{valid: bvalid_q, resp: AXIL_OKAY};
   assign s_r = '{valid: rvalid_q, data: rsel_buf_q ? rd_data : rdata_q, resp: rresp_q};

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         awready_q <= 1'b0;
         bvalid_q  <= 1'b0;
         arready_q <= 1'b0;
         rvalid_q  <= 1'b0;
         rd_addr_q <= '0;
      end else begin
         // address and data taken together
         awready_q <= s_aw.valid && s_w.valid && !awready_q && !bvalid_q;
         if (wr_go) begin
            bvalid_q <= 1'b1;
         end else if (s_bready) begin
            bvalid_q <= 1'b0;
         end
         arready_q <= s_ar.valid && !arready_q && !rvalid_q;
         if (rd_go) begin
            rvalid_q  <= 1'b1;
            rd_addr_q <= ar_off[10:2];
         end else if (s_rready) begin
            rvalid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge RX_CLK) begin
      if (rd_go) begin
         rsel_buf_q <= 1'b0;
         rdata_q    <= '0;
         rresp_q    <= AXIL_OKAY;
         case (s_ar.addr)
            `ETH_RX_REG_STATUS: rdata_q <= {31'd0, frame_ready};
            `ETH_RX_REG_LENGTH: rdata_q <= {21'd0, frame_len};
            `ETH_RX_REG_DROPS:  rdata_q <= {16'd0, drop_count};
            default: begin
               if (ar_in_buf) begin
                  rsel_buf_q <= 1'b1;
               end else begin
                  rresp_q <= AXIL_SLVERR;
               end
            end
         endcase
      end
   end

endmodule

// File: hdl/eth_rx_config.svh
`ifndef ETH_RX_CONFIG_SVH
`define ETH_RX_CONFIG_SVH

// station address, first byte on the wire in bits 47:40
`define ETH_RX_MAC_ADDR 48'h02_1A_2B_3C_4D_5E

// frame buffer depth in bytes
`define ETH_RX_BUF_BYTES 2048

// accepted frame sizes, FCS included
`define ETH_RX_MIN_BYTES 11'd64
`define ETH_RX_MAX_BYTES 11'd1518

// CRC register left over a good frame and its FCS
// (reflected form, no final inversion)
`define ETH_RX_CRC_RESIDUE 32'hDEBB20E3

// host register byte offsets
`define ETH_RX_REG_STATUS 12'h000
`define ETH_RX_REG_LENGTH 12'h004
`define ETH_RX_REG_DROPS 12'h008
`define ETH_RX_REG_DATA 12'h100

`endif

// File: hdl/eth_rx_crc.sv
`include "eth_rx_config.svh"

module eth_rx_crc
   import eth_rx_frame_pkg::*;
(
   input  logic          RX_CLK,
   input  logic          rx_rst,
   input  rx_byte_t      rx_byte,
   output check_result_t crc_result
);

   localparam logic [31:0] POLY = 32'hEDB88320;

   logic [31:0] crc_q;

   // one byte through the reflected CRC-32, lsb first
   function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      c = crc ^ {24'd0, data};
      for (int i = 0; i < 8; i++) begin
         c = c[0] ? ((c >> 1) ^ POLY) : (c >> 1);
      end
      return c;
   endfunction

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         crc_q      <= '1;
         crc_result <= '0;
      end else begin
         crc_result.done <= rx_byte.eof;
         crc_result.ok   <= rx_byte.eof && (crc_q == `ETH_RX_CRC_RESIDUE);
         if (rx_byte.valid) begin
            // reseed on the first byte of each frame
            crc_q <= crc_byte(rx_byte.sof ? 32'hFFFF_FFFF : crc_q, rx_byte.data);
         end
      end
   end

endmodule

// File: hdl/eth_rx_frame_pkg.sv
package eth_rx_frame_pkg;

   // one byte of the receive stream
   // eof rides alone in the cycle after the last byte
   typedef struct packed {
      logic [7:0] data;
      logic       valid;
      logic       sof;
      logic       eof;
   } rx_byte_t;

   // byte count of a frame
   typedef logic [10:0] frame_len_t;

   // verdict from one frame checker, ok qualified by done
   typedef struct packed {
      logic done;
      logic ok;
   } check_result_t;

endpackage

// File: hdl/eth_rx_frame_store.sv
`include "eth_rx_config.svh"

module eth_rx_frame_store
   import eth_rx_frame_pkg::*;
(
   input  logic          RX_CLK,
   input  logic          rx_rst,
   input  rx_byte_t      rx_byte,
   input  check_result_t crc_result,
   input  check_result_t mac_result,
   input  logic          buf_release,
   input  logic [8:0]    rd_addr,
   output logic [31:0]   rd_data,
   output logic          frame_ready,
   output frame_len_t    frame_len,
   output logic [15:0]   drop_count
);

   localparam int WORDS = `ETH_RX_BUF_BYTES / 4;

   // byte lane 0 holds the lowest address of each word
   logic [3:0][7:0] buf_mem [WORDS];

   frame_len_t cnt_q;
   frame_len_t wr_idx;
   logic       wr_en;
   logic       take_q;
   logic       verdict;
   logic       accept;

   assign wr_idx  = rx_byte.sof ? '0 : cnt_q;
   assign wr_en   = rx_byte.valid &&
                    (rx_byte.sof ? !frame_ready : (take_q && cnt_q != '1));
   assign verdict = crc_result.done && mac_result.done;
   assign accept  = take_q && crc_result.ok && mac_result.ok &&
                    (cnt_q >= `ETH_RX_MIN_BYTES) && (cnt_q <= `ETH_RX_MAX_BYTES);

   always_ff @(posedge RX_CLK) begin
      if (wr_en) begin
         buf_mem[wr_idx[10:2]][wr_idx[1:0]] <= rx_byte.data;
      end
      rd_data <= buf_mem[rd_addr];
   end

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         cnt_q       <= '0;
         take_q      <= 1'b0;
         frame_ready <= 1'b0;
         frame_len   <= '0;
         drop_count  <= '0;
      end else begin
         if (rx_byte.valid) begin
            if (rx_byte.sof) begin
               cnt_q  <= 11'd1;
               // a full buffer turns the whole frame away
               take_q <= !frame_ready;
            end else if (cnt_q != '1) begin
               cnt_q <= cnt_q + 11'd1;
            end
         end
         if (buf_release) begin
            frame_ready <= 1'b0;
         end
         if (verdict) begin
            take_q <= 1'b0;
            if (accept) begin
               frame_ready <= 1'b1;
               frame_len   <= cnt_q - 11'd4;
            end else if (drop_count != '1) begin
               drop_count <= drop_count + 16'd1;
            end
         end
      end
   end

endmodule

// File: hdl/eth_rx_mac_filter.sv
`include "eth_rx_config.svh"

module eth_rx_mac_filter
   import eth_rx_frame_pkg::*;
(
   input  logic          RX_CLK,
   input  logic          rx_rst,
   input  rx_byte_t      rx_byte,
   output check_result_t mac_result
);

   logic [47:0] dest_q;
   logic [2:0]  cnt_q;
   logic        match;

   assign match = (cnt_q == 3'd6) &&
                  ((dest_q == `ETH_RX_MAC_ADDR) || (dest_q == 48'hFFFF_FFFF_FFFF));

   // destination bytes, first one ends up on top
   always_ff @(posedge RX_CLK) begin
      if (rx_byte.valid) begin
         if (rx_byte.sof) begin
            dest_q <= {40'd0, rx_byte.data};
         end else if (cnt_q != 3'd6) begin
            dest_q <= {dest_q[39:0], rx_byte.data};
         end
      end
   end

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         cnt_q      <= 3'd0;
         mac_result <= '0;
      end else begin
         if (rx_byte.valid) begin
            if (rx_byte.sof) begin
               cnt_q <= 3'd1;
            end else if (cnt_q != 3'd6) begin
               cnt_q <= cnt_q + 3'd1;
            end
         end
         mac_result.done <= rx_byte.eof;
         mac_result.ok   <= rx_byte.eof && match;
      end
   end

endmodule

// File: hdl/eth_rx_mii.sv
module eth_rx_mii
   import eth_rx_frame_pkg::*;
(
   input  logic       RX_CLK,
   input  logic       rx_rst,
   input  logic       rx_dv,
   input  logic [3:0] rx_data,
   output rx_byte_t   rx_byte
);

   localparam logic [7:0] SFD = 8'hD5;

   logic       dv_q;
   logic       dv_d;
   logic [3:0] nib_q;
   logic [3:0] nib_d;
   logic [7:0] assembled;
   logic       in_frame;
   logic       phase;
   logic       first;

   // low nibble arrives first
   assign assembled = {nib_q, nib_d};

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         dv_q <= 1'b0;
         dv_d <= 1'b0;
      end else begin
         dv_q <= rx_dv;
         dv_d <= dv_q;
      end
   end

   always_ff @(posedge RX_CLK) begin
      nib_q <= rx_data;
      nib_d <= nib_q;
   end

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         in_frame <= 1'b0;
         phase    <= 1'b0;
         first    <= 1'b0;
         rx_byte  <= '0;
      end else begin
         rx_byte.data  <= assembled;
         rx_byte.valid <= 1'b0;
         rx_byte.sof   <= 1'b0;
         rx_byte.eof   <= 1'b0;
         if (!dv_q) begin
            rx_byte.eof <= in_frame;
            in_frame    <= 1'b0;
         end else if (!in_frame) begin
            // sfd hunt, one try per nibble
            if (dv_d && assembled == SFD) begin
               in_frame <= 1'b1;
               phase    <= 1'b0;
               first    <= 1'b1;
            end
         end else begin
            phase <= ~phase;
            if (phase) begin
               rx_byte.valid <= 1'b1;
               rx_byte.sof   <= first;
               first         <= 1'b0;
            end
         end
      end
   end

endmodule

// File: hdl/eth_rx_top.sv
module eth_rx_top
   import eth_rx_frame_pkg::*;
   import eth_rx_axil_pkg::*;
(
   input  logic       RX_CLK,
   input  logic       rx_rst,
   input  logic       rx_dv,
   input  logic [3:0] rx_data,
   input  axil_aw_t   s_aw,
   output logic       s_awready,
   input  axil_w_t    s_w,
   output logic       s_wready,
   output axil_b_t    s_b,
   input  logic       s_bready,
   input  axil_ar_t   s_ar,
   output logic       s_arready,
   output axil_r_t    s_r,
   input  logic       s_rready
);

   rx_byte_t      rx_byte;
   check_result_t crc_result;
   check_result_t mac_result;
   logic          buf_release;
   logic [8:0]    rd_addr;
   logic [31:0]   rd_data;
   logic          frame_ready;
   frame_len_t    frame_len;
   logic [15:0]   drop_count;

   eth_rx_mii eth_rx_mii_inst (
      .RX_CLK  (RX_CLK),
      .rx_rst  (rx_rst),
      .rx_dv   (rx_dv),
      .rx_data (rx_data),
      .rx_byte (rx_byte)
   );

   // both checks watch the same stream
   eth_rx_crc eth_rx_crc_inst (
      .RX_CLK     (RX_CLK),
      .rx_rst     (rx_rst),
      .rx_byte    (rx_byte),
      .crc_result (crc_result)
   );

   eth_rx_mac_filter eth_rx_mac_filter_inst (
      .RX_CLK     (RX_CLK),
      .rx_rst     (rx_rst),
      .rx_byte    (rx_byte),
      .mac_result (mac_result)
   );

   eth_rx_frame_store eth_rx_frame_store_inst (
      .RX_CLK      (RX_CLK),
      .rx_rst      (rx_rst),
      .rx_byte     (rx_byte),
      .crc_result  (crc_result),
      .mac_result  (mac_result),
      .buf_release (buf_release),
      .rd_addr     (rd_addr),
      .rd_data     (rd_data),
      .frame_ready (frame_ready),
      .frame_len   (frame_len),
      .drop_count  (drop_count)
   );

   eth_rx_axil_regs eth_rx_axil_regs_inst (
      .RX_CLK      (RX_CLK),
      .rx_rst      (rx_rst),
      .s_aw        (s_aw),
      .s_awready   (s_awready),
      .s_w         (s_w),
      .s_wready    (s_wready),
      .s_b         (s_b),
      .s_bready    (s_bready),
      .s_ar        (s_ar),
      .s_arready   (s_arready),
      .s_r         (s_r),
      .s_rready    (s_rready),
      .frame_ready (frame_ready),
      .frame_len   (frame_len),
      .drop_count  (drop_count),
      .rd_data     (rd_data),
      .rd_addr     (rd_addr),
      .buf_release (buf_release)
   );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
     --top-module eth_rx_tb -f compile.f -o eth_rx_sim &&
  ./obj_dir/eth_rx_sim ; } > sim.log 2>&1 || echo "RESULT: FAIL" >> sim.log
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation failed"; exit 1; }
echo "simulation passed"

// File: testbench/eth_rx_asserts.sv
module eth_rx_asserts
   import eth_rx_frame_pkg::*;
   import eth_rx_axil_pkg::*;
(
   input logic     RX_CLK,
   input logic     rx_rst,
   input rx_byte_t rx_byte,
   input axil_b_t  s_b,
   input logic     s_bready,
   input axil_r_t  s_r,
   input logic     s_rready
);
   timeunit 1ns;
   timeprecision 1ps;

   // bytes of a frame never come back to back
   byte_spacing: assert property (@(posedge RX_CLK) disable iff (rx_rst)
      rx_byte.valid |=> !rx_byte.valid)
      else $error("receive byte valid in two consecutive cycles");

   eof_alone: assert property (@(posedge RX_CLK) disable iff (rx_rst)
      rx_byte.eof |-> !rx_byte.valid)
      else $error("end of frame mark came together with a valid byte");

   // response held while the host stalls
   b_hold: assert property (@(posedge RX_CLK) disable iff (rx_rst)
      s_b.valid && !s_bready |=> s_b.valid && $stable(s_b.resp))
      else $error("write response dropped or changed before bready");

   r_hold: assert property (@(posedge RX_CLK) disable iff (rx_rst)
      s_r.valid && !s_rready |=> s_r.valid && $stable(s_r.data) && $stable(s_r.resp))
      else $error("read response dropped or changed before rready");

endmodule

// File: testbench/eth_rx_tb.sv
`include "eth_rx_config.svh"

module eth_rx_tb
   import eth_rx_frame_pkg::*;
   import eth_rx_axil_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int          AXI_TIMEOUT     = 100;
   localparam int          OUTCOME_TIMEOUT = 50;
   localparam logic [47:0] SRC_ADDR        = 48'h02_00_00_00_00_01;
   localparam logic [47:0] BCAST_ADDR      = 48'hFFFF_FFFF_FFFF;

   logic       RX_CLK;
   logic       rx_rst;
   logic       rx_dv;
   logic [3:0] rx_data;
   axil_aw_t   s_aw;
   logic       s_awready;
   axil_w_t    s_w;
   logic       s_wready;
   axil_b_t    s_b;
   logic       s_bready;
   axil_ar_t   s_ar;
   logic       s_arready;
   axil_r_t    s_r;
   logic       s_rready;

   integer      seed;
   string       test_name;
   logic [7:0]  tx_frame[$];
   logic [7:0]  exp_bytes[$];
   logic        model_ready;
   frame_len_t  model_len;
   logic [31:0] model_drops;

   eth_rx_top eth_rx_top_inst (
      .RX_CLK    (RX_CLK),
      .rx_rst    (rx_rst),
      .rx_dv     (rx_dv),
      .rx_data   (rx_data),
      .s_aw      (s_aw),
      .s_awready (s_awready),
      .s_w       (s_w),
      .s_wready  (s_wready),
      .s_b       (s_b),
      .s_bready  (s_bready),
      .s_ar      (s_ar),
      .s_arready (s_arready),
      .s_r       (s_r),
      .s_rready  (s_rready)
   );

   bind eth_rx_top eth_rx_asserts eth_rx_asserts_inst (
      .RX_CLK   (RX_CLK),
      .rx_rst   (rx_rst),
      .rx_byte  (rx_byte),
      .s_b      (s_b),
      .s_bready (s_bready),
      .s_r      (s_r),
      .s_rready (s_rready)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #4 RX_CLK = ~RX_CLK;
   end

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h",
                                 name, expected, actual));
      end
   endtask

   task automatic check_len(input string name, input frame_len_t expected,
                            input frame_len_t actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("[ERROR] %s: expected %0d, actual %0d",
                                 name, expected, actual));
      end
   endtask

   task automatic check_resp(input string name, input axil_resp_t expected,
                             input axil_resp_t actual);
      if (actual !== expected) begin
         stop_on_error($sformatf("[ERROR] %s: expected %s, actual %s (%b)",
                                 name, expected.name(), actual.name(), actual));
      end
   endtask

   // bit-serial CRC-32 over the first n bytes, complemented for the FCS field
   function automatic logic [31:0] frame_crc(input int n);
      logic [31:0] crc;
      logic        fb;
      crc = 32'hFFFF_FFFF;
      for (int i = 0; i < n; i++) begin
         for (int b = 0; b < 8; b++) begin
            fb  = crc[0] ^ tx_frame[i][b];
            crc = crc >> 1;
            if (fb) crc = crc ^ 32'hEDB8_8320;
         end
      end
      return ~crc;
   endfunction

   // expected verdict for the n bytes now in tx_frame
   function automatic logic frame_expected(input int n, input logic buffer_full);
      logic [47:0] dest;
      logic [31:0] fcs;
      dest = {tx_frame[0], tx_frame[1], tx_frame[2], tx_frame[3], tx_frame[4], tx_frame[5]};
      fcs  = {tx_frame[n-1], tx_frame[n-2], tx_frame[n-3], tx_frame[n-4]};
      return !buffer_full && (dest == `ETH_RX_MAC_ADDR || dest == BCAST_ADDR) &&
             fcs == frame_crc(n - 4) &&
             n >= `ETH_RX_MIN_BYTES && n <= `ETH_RX_MAX_BYTES;
   endfunction

   task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                             output axil_resp_t resp);
      logic [31:0] rnd;
      int          n;
      @(negedge RX_CLK);
      s_aw = '{valid: 1'b1, addr: addr};
      s_w  = '{valid: 1'b1, data: data, strb: 4'hF};
      n = 0;
      while (!(s_awready && s_wready)) begin
         @(negedge RX_CLK);
         n++;
         if (n > AXI_TIMEOUT) stop_on_error("timeout waiting for awready and wready");
      end
      @(negedge RX_CLK);
      s_aw = '0;
      s_w  = '0;
      n = 0;
      while (!s_b.valid) begin
         @(negedge RX_CLK);
         n++;
         if (n > AXI_TIMEOUT) stop_on_error("timeout waiting for bvalid");
      end
      // stall the response a little
      rnd = $random(seed);
      repeat (rnd[1:0]) @(negedge RX_CLK);
      resp = s_b.resp;
      s_bready = 1'b1;
      @(negedge RX_CLK);
      s_bready = 1'b0;
   endtask

   task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                            output axil_resp_t resp);
      logic [31:0] rnd;
      int          n;
      @(negedge RX_CLK);
      s_ar = '{valid: 1'b1, addr: addr};
      n = 0;
      while (!s_arready) begin
         @(negedge RX_CLK);
         n++;
         if (n > AXI_TIMEOUT) stop_on_error("timeout waiting for arready");
      end
      @(negedge RX_CLK);
      s_ar = '0;
      n = 0;
      while (!s_r.valid) begin
         @(negedge RX_CLK);
         n++;
         if (n > AXI_TIMEOUT) stop_on_error("timeout waiting for rvalid");
      end
      rnd = $random(seed);
      repeat (rnd[1:0]) @(negedge RX_CLK);
      data = s_r.data;
      resp = s_r.resp;
      s_rready = 1'b1;
      @(negedge RX_CLK);
      s_rready = 1'b0;
   endtask

   task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
      axil_resp_t resp;
      axil_read(addr, data, resp);
      check_resp(test_name, AXIL_OKAY, resp);
   endtask

   task automatic build_frame(input logic [47:0] dest, input int payload_len,
                              input logic corrupt);
      logic [31:0] fcs;
      logic [31:0] rnd;
      tx_frame.delete();
      for (int i = 5; i >= 0; i--) tx_frame.push_back(dest[8*i +: 8]);
      for (int i = 5; i >= 0; i--) tx_frame.push_back(SRC_ADDR[8*i +: 8]);
      tx_frame.push_back(8'h08);
      tx_frame.push_back(8'h00);
      for (int i = 0; i < payload_len; i++) begin
         rnd = $random(seed);
         tx_frame.push_back(rnd[7:0]);
      end
      fcs = frame_crc(tx_frame.size());
      if (corrupt) fcs = fcs ^ 32'h0000_0100;
      // FCS goes out least significant byte first
      for (int i = 0; i < 4; i++) tx_frame.push_back(fcs[8*i +: 8]);
   endtask

   task automatic drive_byte(input logic [7:0] b);
      @(negedge RX_CLK);
      rx_dv   = 1'b1;
      rx_data = b[3:0];
      @(negedge RX_CLK);
      rx_data = b[7:4];
   endtask

   task automatic drive_frame();
      logic [31:0] rnd;
      int          gap;
      for (int i = 0; i < 7; i++) drive_byte(8'h55);
      drive_byte(8'hD5);
      foreach (tx_frame[i]) drive_byte(tx_frame[i]);
      @(negedge RX_CLK);
      rx_dv   = 1'b0;
      rx_data = 4'h0;
      // at least 12 idle byte times
      rnd = $random(seed);
      gap = 24 + 2 * int'(rnd[3:0]);
      repeat (gap - 1) @(negedge RX_CLK);
   endtask

   task automatic compare_state();
      logic [31:0] d;
      logic [31:0] expected;
      int          words;
      read_reg(`ETH_RX_REG_STATUS, d);
      check_word({test_name, " status"}, {31'd0, model_ready}, d);
      read_reg(`ETH_RX_REG_DROPS, d);
      check_word({test_name, " drops"}, model_drops, d);
      if (model_ready) begin
         read_reg(`ETH_RX_REG_LENGTH, d);
         check_len({test_name, " length"}, model_len, d[10:0]);
         words = (int'(model_len) + 3) / 4;
         for (int w = 0; w < words; w++) begin
            read_reg(`ETH_RX_REG_DATA + 12'(4 * w), d);
            expected = {exp_bytes[4*w+3], exp_bytes[4*w+2], exp_bytes[4*w+1], exp_bytes[4*w]};
            check_word($sformatf("%s data word %0d", test_name, w), expected, d);
         end
      end
   endtask

   // poll until STATUS or DROPS moves away from its old value
   task automatic wait_outcome(input logic ready_before, input logic [31:0] drops_before);
      logic [31:0] st;
      logic [31:0] dr;
      int          n;
      n = 0;
      read_reg(`ETH_RX_REG_STATUS, st);
      read_reg(`ETH_RX_REG_DROPS, dr);
      while (st[0] == ready_before && dr == drops_before) begin
         n++;
         if (n > OUTCOME_TIMEOUT) begin
            stop_on_error({test_name, ": frame was neither accepted nor dropped in time"});
         end
         read_reg(`ETH_RX_REG_STATUS, st);
         read_reg(`ETH_RX_REG_DROPS, dr);
      end
   endtask

   task automatic send_frame(input logic [47:0] dest, input int payload_len,
                             input logic corrupt);
      logic        ready_before;
      logic [31:0] drops_before;
      int          n;
      ready_before = model_ready;
      drops_before = model_drops;
      build_frame(dest, payload_len, corrupt);
      n = tx_frame.size();
      if (frame_expected(n, ready_before)) begin
         model_ready = 1'b1;
         model_len   = frame_len_t'(n - 4);
         exp_bytes   = tx_frame;
      end else if (model_drops != 32'h0000_FFFF) begin
         model_drops = model_drops + 32'd1;
      end
      drive_frame();
      wait_outcome(ready_before, drops_before);
      compare_state();
   endtask

   task automatic release_buffer();
      axil_resp_t resp;
      axil_write(`ETH_RX_REG_STATUS, 32'h1, resp);
      check_resp(test_name, AXIL_OKAY, resp);
      model_ready = 1'b0;
      compare_state();
   endtask

   initial begin
      logic [31:0] d;
      logic [31:0] rnd;
      axil_resp_t  resp;
      seed        = 32'h8b765fa7;
      rx_rst      = 1'b1;
      rx_dv       = 1'b0;
      rx_data     = 4'h0;
      s_aw        = '0;
      s_w         = '0;
      s_bready    = 1'b0;
      s_ar        = '0;
      s_rready    = 1'b0;
      model_ready = 1'b0;
      model_len   = '0;
      model_drops = '0;
      test_name   = "after reset";
      repeat (4) @(posedge RX_CLK);
      @(negedge RX_CLK);
      rx_rst = 1'b0;
      compare_state();

      test_name = "good frame to local address";
      send_frame(`ETH_RX_MAC_ADDR, 46, 1'b0);
      test_name = "second frame before release";
      send_frame(`ETH_RX_MAC_ADDR, 60, 1'b0);
      test_name = "release of first frame";
      release_buffer();

      test_name = "corrupted fcs";
      send_frame(`ETH_RX_MAC_ADDR, 50, 1'b1);
      test_name = "foreign address";
      send_frame(48'h02_1A_2B_3C_4D_5F, 50, 1'b0);
      test_name = "40-byte frame";
      send_frame(`ETH_RX_MAC_ADDR, 22, 1'b0);
      test_name = "broadcast frame";
      send_frame(BCAST_ADDR, 52, 1'b0);
      test_name = "release of broadcast frame";
      release_buffer();

      test_name = "good frame after release";
      rnd = $random(seed);
      send_frame(`ETH_RX_MAC_ADDR, 46 + int'(rnd[5:0]), 1'b0);

      test_name = "unmapped read";
      axil_read(12'h00C, d, resp);
      check_resp(test_name, AXIL_SLVERR, resp);
      check_word(test_name, 32'd0, d);
      axil_read(12'h900, d, resp);
      check_resp(test_name, AXIL_SLVERR, resp);
      check_word(test_name, 32'd0, d);

      test_name = "write to length";
      axil_write(`ETH_RX_REG_LENGTH, 32'h0000_05A5, resp);
      check_resp(test_name, AXIL_OKAY, resp);
      compare_state();

      $display("RESULT: PASS");
      $finish;
   end

endmodule
